// ==== sources.f ====
verilog/pwmRegPkg.sv
verilog/pwmAudioPkg.sv
verilog/pwmRegFile.sv
verilog/pulseQueue.sv
verilog/pwmTimer.sv
verilog/pwmSampleScaler.sv
verilog/pwmAudioTop.sv
sim/pwmAudioTb_chk.sv
sim/pwmAudioTb.sv

// ==== sim/pwmAudioTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmAudioTb;
	import pwmRegPkg::*;
	import pwmAudioPkg::*;

	localparam int TABLE_LEN = 40;
	localparam int MAX_CYCLE = 2048 + 63;
	localparam int IRQ_CYCLE = 16;
	localparam int WATCH_CYCLES = 2 * (TABLE_LEN * 3 + 9 * 40 + 9 * 4 * (MAX_CYCLE + 8)
		+ 3 * 4 * (IRQ_CYCLE + 8));
	localparam logic WR = 1'b1;
	localparam logic RD = 1'b0;

	typedef struct packed {
		logic [3:0]  test;
		logic        isWrite;
		regOffset_t  ofs;
		logic [1:0]  be;
		logic [15:0] data;
		logic [15:0] expData;
	} entry_t;

	logic        CLK;
	logic        RST_N;
	logic        tick;
	regBus_t     bus;
	logic [15:0] rdata;
	logic        rdValid;
	sample_t     sampleL;
	sample_t     sampleR;
	logic        pwmIrq;
	logic        dmaReq;

	entry_t      stim [TABLE_LEN];
	int          nEntries;
	int          errors;
	int          testCount;
	int          failedTests;
	int          testStartErrors;
	int          assertsCounted;
	logic [31:0] lfsrState;
	sample_t     expL [3];
	sample_t     expR [3];

	pwmAudioTop DUT (
		.CLK(CLK), .RST_N(RST_N), .tick(tick), .bus(bus), .rdata(rdata), .rdValid(rdValid),
		.sampleL(sampleL), .sampleR(sampleR), .pwmIrq(pwmIrq), .dmaReq(dmaReq)
	);

	always #50 CLK = ~CLK;

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic int unsigned takeBits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrNext(lfsrState);
			v = (v << 1) | lfsrState[0];
		end
		return v;
	endfunction

	// Expected sample from width and cycle
	function automatic sample_t refSample(input int pw, input int cyc);
		int          half;
		int          off;
		logic [11:0] v;
		half = cyc / 2;
		if (pw == 0) off = 0;
		else if (pw > cyc) off = half;
		else off = pw - half;
		v = off[11:0];
		if (cyc < 2048) return {v[11], v[9:0], 5'b00000};
		return {v, 4'b0000};
	endfunction

	function automatic sample_t currentSample(input bit right);
		return right ? sampleR : sampleL;
	endfunction

	task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] want);
		if (got !== want) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	task automatic addEntry(input int testNo, input logic isWr, input regOffset_t ofs,
			input logic [1:0] be, input logic [15:0] data, input logic [15:0] expData);
		stim[nEntries].test    = testNo[3:0];
		stim[nEntries].isWrite = isWr;
		stim[nEntries].ofs     = ofs;
		stim[nEntries].be      = be;
		stim[nEntries].data    = data;
		stim[nEntries].expData = expData;
		nEntries++;
	endtask

	task automatic buildTable();
		addEntry(1, RD, PWM_CTRL_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(1, RD, CYCLE_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(1, RD, INT_MASK_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(1, RD, LEFT_PW_OFS, 2'b11, 16'h0000, 16'h4000);
		addEntry(1, RD, RIGHT_PW_OFS, 2'b11, 16'h0000, 16'h4000);
		addEntry(1, RD, MONO_PW_OFS, 2'b11, 16'h0000, 16'h4000);
		addEntry(2, WR, CYCLE_OFS, 2'b11, 16'hFFFF, 16'h0000);
		addEntry(2, RD, CYCLE_OFS, 2'b11, 16'h0000, 16'h0FFF);
		addEntry(2, WR, CYCLE_OFS, 2'b10, 16'h0000, 16'h0000);
		addEntry(2, RD, CYCLE_OFS, 2'b11, 16'h0000, 16'h00FF);	// Lower lane kept
		addEntry(2, WR, PWM_CTRL_OFS, 2'b01, 16'hFFFF, 16'h0000);
		addEntry(2, RD, PWM_CTRL_OFS, 2'b11, 16'h0000, 16'h009F);
		addEntry(2, WR, PWM_CTRL_OFS, 2'b10, 16'h5A00, 16'h0000);
		addEntry(2, RD, PWM_CTRL_OFS, 2'b11, 16'h0000, 16'h0A9F);
		addEntry(2, WR, PWM_CTRL_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(2, RD, PWM_CTRL_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(2, WR, INT_MASK_OFS, 2'b11, 16'hFFFF, 16'h0000);
		addEntry(2, RD, INT_MASK_OFS, 2'b11, 16'h0000, 16'h0001);
		addEntry(2, WR, INT_MASK_OFS, 2'b10, 16'hFF00, 16'h0000);
		addEntry(2, RD, INT_MASK_OFS, 2'b11, 16'h0000, 16'h0001);
		addEntry(2, WR, INT_MASK_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(2, RD, INT_MASK_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(3, WR, LEFT_PW_OFS, 2'b11, 16'h0123, 16'h0000);
		addEntry(3, WR, LEFT_PW_OFS, 2'b11, 16'h0234, 16'h0000);
		addEntry(3, WR, LEFT_PW_OFS, 2'b11, 16'h0345, 16'h0000);
		addEntry(3, RD, LEFT_PW_OFS, 2'b11, 16'h0000, 16'h8000);
		addEntry(3, WR, LEFT_PW_OFS, 2'b11, 16'h0456, 16'h0000);	// Dropped, queue full
		addEntry(3, RD, LEFT_PW_OFS, 2'b11, 16'h0000, 16'h8000);
		addEntry(3, RD, RIGHT_PW_OFS, 2'b11, 16'h0000, 16'h4000);
		addEntry(3, WR, MONO_PW_OFS, 2'b11, 16'h0789, 16'h0000);
		addEntry(3, RD, MONO_PW_OFS, 2'b11, 16'h0000, 16'h0000);
		addEntry(3, RD, LEFT_PW_OFS, 2'b11, 16'h0000, 16'h8000);
		addEntry(3, RD, RIGHT_PW_OFS, 2'b11, 16'h0000, 16'h0000);
	endtask

	task automatic applyReset();
		@(posedge CLK);
		RST_N <= 1'b0;
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
	endtask

	task automatic busWrite(input regOffset_t ofs, input logic [1:0] be, input logic [15:0] data);
		@(posedge CLK);
		bus <= '{sel: 1'b1, write: 1'b1, addr: ofs, byteEn: be, wdata: data};
		@(posedge CLK);
		bus <= '0;
	endtask

	task automatic busRead(input regOffset_t ofs, output logic [15:0] data);
		@(posedge CLK);
		bus <= '{sel: 1'b1, write: 1'b0, addr: ofs, byteEn: 2'b11, wdata: 16'h0000};
		@(posedge CLK);
		bus <= '0;
		@(negedge CLK);	// rdata settled one cycle after the request
		if (!rdValid) begin
			$display("Read from offset %h came back without rdValid", ofs);
			errors++;
		end
		data = rdata;
	endtask

	task automatic applyTable(input int testNo);
		logic [15:0] got;
		for (int i = 0; i < nEntries; i++) begin
			if (stim[i].test == testNo[3:0]) begin
				if (stim[i].isWrite) begin
					busWrite(stim[i].ofs, stim[i].be, stim[i].data);
				end else begin
					busRead(stim[i].ofs, got);
					checkValue($sformatf("read of offset %h", stim[i].ofs), got, stim[i].expData);
				end
			end
		end
	endtask

	// Equal neighbours produce no visible change and are skipped
	task automatic watchSamples(input bit right, input int cyc);
		sample_t cur;
		sample_t want;
		int      waited;
		cur = '0;
		for (int i = 0; i < 3; i++) begin
			want = right ? expR[i] : expL[i];
			if (want != cur) begin
				waited = 0;
				while (currentSample(right) == cur && waited < 4 * (cyc + 8)) begin
					@(negedge CLK);
					waited++;
				end
				if (currentSample(right) == cur) begin
					$display("Timed out waiting for %s sample %0d", right ? "right" : "left", i);
					errors++;
					return;
				end
				checkValue($sformatf("%s sample %0d", right ? "right" : "left", i),
					currentSample(right), want);
				cur = currentSample(right);
			end
		end
	endtask

	task automatic runConversion(input int cyc, input bit mono);
		int pwLeft [3];
		int pwRight [3];
		applyReset();
		busWrite(CYCLE_OFS, 2'b11, 16'(cyc));
		pwLeft[0] = 0;
		pwLeft[1] = 1 + int'(takeBits(12) % cyc);
		pwLeft[2] = cyc + 1 + int'(takeBits(4));	// Above the cycle
		pwRight[0] = 1 + int'(takeBits(12) % cyc);
		pwRight[1] = cyc + 1 + int'(takeBits(4));
		pwRight[2] = 1 + int'(takeBits(12) % cyc);
		if (mono) begin
			for (int i = 0; i < 3; i++) begin
				busWrite(LEFT_PW_OFS, 2'b11, 16'(pwRight[i]));	// Left queue holds other widths
			end
		end
		for (int i = 0; i < 3; i++) begin
			expL[i] = refSample(pwLeft[i], cyc);
			if (mono) begin
				busWrite(MONO_PW_OFS, 2'b11, 16'(pwLeft[i]));
				expR[i] = expL[i];
			end else begin
				busWrite(LEFT_PW_OFS, 2'b11, 16'(pwLeft[i]));
				busWrite(RIGHT_PW_OFS, 2'b11, 16'(pwRight[i]));
				expR[i] = refSample(pwRight[i], cyc);
			end
		end
		busWrite(PWM_CTRL_OFS, 2'b11, mono ? 16'h0015 : 16'h0005);
		fork
			watchSamples(1'b0, cyc);
			watchSamples(1'b1, cyc);
		join
		if (mono) checkValue("mono sampleL against sampleR", sampleL, sampleR);
	endtask

	task automatic runInterrupt();
		int          waited;
		bit          dmaSeen;
		logic [15:0] got;
		applyReset();
		busWrite(CYCLE_OFS, 2'b11, 16'(IRQ_CYCLE));
		busWrite(INT_MASK_OFS, 2'b11, 16'h0001);
		busWrite(PWM_CTRL_OFS, 2'b11, 16'h0381);	// Interval 3, rtp, left on
		waited = 0;
		dmaSeen = 1'b0;
		while (!(pwmIrq && dmaSeen) && waited < 4 * (IRQ_CYCLE + 8)) begin
			@(negedge CLK);
			if (dmaReq) dmaSeen = 1'b1;
			waited++;
		end
		if (!pwmIrq || !dmaSeen) begin
			$display("Timed out waiting for the interrupt and the DMA request");
			errors++;
		end
		@(negedge CLK);
		checkValue("dmaReq one tick after the pulse", 16'(dmaReq), 16'h0000);
		busRead(INT_MASK_OFS, got);
		checkValue("interrupt status", got, 16'h0009);
		busWrite(PWM_CTRL_OFS, 2'b11, 16'h0000);
		busWrite(PWM_CLR_OFS, 2'b11, 16'h0000);
		@(negedge CLK);
		checkValue("pwmIrq after clear", 16'(pwmIrq), 16'h0000);
		busWrite(INT_MASK_OFS, 2'b11, 16'h0000);
		busWrite(PWM_CTRL_OFS, 2'b11, 16'h0381);
		for (waited = 0; waited < 4 * (IRQ_CYCLE + 8); waited++) begin
			@(negedge CLK);
			if (pwmIrq) begin
				$display("pwmIrq rose although the interrupt mask is cleared");
				errors++;
				break;
			end
		end
	endtask

	task automatic endTest(input string name);
		errors += DUT.chk.assertFails - assertsCounted;	// Bound assertion failures
		assertsCounted = DUT.chk.assertFails;
		testCount++;
		if (errors != testStartErrors) begin
			failedTests++;
			$display("Test %0d %s: failed, %0d errors", testCount, name, errors - testStartErrors);
		end else begin
			$display("Test %0d %s: ok", testCount, name);
		end
		testStartErrors = errors;
	endtask

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		tick = 1'b0;
		bus = '0;
		lfsrState = 32'h271ae475;
		errors = 0;
		testCount = 0;
		failedTests = 0;
		testStartErrors = 0;
		assertsCounted = 0;
		nEntries = 0;
		buildTable();
		repeat (3) @(posedge CLK);
		RST_N <= 1'b1;
		tick <= 1'b1;

		@(negedge CLK);
		checkValue("rdValid after reset", 16'(rdValid), 16'h0000);
		applyTable(1);
		checkValue("pwmIrq after reset", 16'(pwmIrq), 16'h0000);
		checkValue("dmaReq after reset", 16'(dmaReq), 16'h0000);
		checkValue("sampleL after reset", sampleL, 16'h0000);
		checkValue("sampleR after reset", sampleR, 16'h0000);
		endTest("reset state");
		applyTable(2);
		endTest("masked writes");
		applyTable(3);
		endTest("queue status");
		runConversion(16 + int'(takeBits(8)), 1'b0);
		runConversion(2048 + int'(takeBits(6)), 1'b0);	// Cycle bit 11 set
		runConversion(16 + int'(takeBits(8)), 1'b1);
		endTest("sample conversion");
		runInterrupt();
		endTest("interrupt and DMA request");

		$display("%0d tests run, %0d failed, %0d check errors", testCount, failedTests, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCH_CYCLES * 100);
		$display("Watchdog expired before the tests finished");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/pwmAudioTb_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmAudioTbChk (
	input wire CLK,
	input wire RST_N,
	input wire tick,
	input wire leftFull,
	input wire leftEmpty,
	input wire rightFull,
	input wire rightEmpty,
	input wire irqClear,
	input wire pwmIrq,
	input wire dmaReq
);

	int assertFails = 0;

	leftFlags: assert property (@(posedge CLK) disable iff (!RST_N) !(leftFull && leftEmpty))
	else begin
		$error("left queue reports full and empty together");
		assertFails++;
	end

	rightFlags: assert property (@(posedge CLK) disable iff (!RST_N) !(rightFull && rightEmpty))
	else begin
		$error("right queue reports full and empty together");
		assertFails++;
	end

	// Request lasts a single tick
	dmaOneTick: assert property (@(posedge CLK) disable iff (!RST_N) (dmaReq && tick) |=> !dmaReq)
	else begin
		$error("dmaReq held high over two ticks");
		assertFails++;
	end

	irqFall: assert property (@(posedge CLK) disable iff (!RST_N) $fell(pwmIrq) |-> $past(irqClear))
	else begin
		$error("pwmIrq dropped without a clear write");
		assertFails++;
	end

endmodule

bind pwmAudioTop pwmAudioTbChk chk (
	.CLK(CLK),
	.RST_N(RST_N),
	.tick(tick),
	.leftFull(leftFull),
	.leftEmpty(leftEmpty),
	.rightFull(rightFull),
	.rightEmpty(rightEmpty),
	.irqClear(irqClear),
	.pwmIrq(pwmIrq),
	.dmaReq(dmaReq)
);

`default_nettype wire

// ==== verilog/pwmAudioTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmAudioTop (
	input  wire                     CLK,
	input  wire                     RST_N,
	input  wire                     tick,
	input  wire pwmRegPkg::regBus_t bus,
	output logic [15:0]             rdata,
	output logic                    rdValid,
	output pwmAudioPkg::sample_t    sampleL,
	output pwmAudioPkg::sample_t    sampleR,
	output logic                    pwmIrq,
	output logic                    dmaReq
);
	import pwmRegPkg::*;
	import pwmAudioPkg::*;

	pwmCtrl_t    ctrl;
	cycle_t      cycle;
	logic        irqMask;
	logic        irqClear;
	logic        restart;
	logic        pushL;
	logic        pushR;
	pulseWidth_t pwL;
	pulseWidth_t pwR;
	logic        periodEnd;
	logic        pop;
	logic        load;
	logic [1:0]  hasData;
	pulseWidth_t headL;
	pulseWidth_t headR;
	logic        leftFull;
	logic        leftEmpty;
	logic        rightFull;
	logic        rightEmpty;

	pwmRegFile regFile (
		.CLK(CLK), .RST_N(RST_N), .tick(tick), .bus(bus), .periodEnd(periodEnd),
		.irqFlag(pwmIrq), .leftFull(leftFull), .leftEmpty(leftEmpty),
		.rightFull(rightFull), .rightEmpty(rightEmpty), .rdata(rdata), .rdValid(rdValid),
		.ctrl(ctrl), .cycle(cycle), .irqMask(irqMask), .irqClear(irqClear),
		.restart(restart), .pushL(pushL), .pushR(pushR), .pwL(pwL), .pwR(pwR)
	);

	pulseQueue leftQueue (
		.CLK(CLK), .RST_N(RST_N), .push(pushL), .pop(pop), .din(pwL),
		.head(headL), .full(leftFull), .empty(leftEmpty)
	);

	pulseQueue rightQueue (
		.CLK(CLK), .RST_N(RST_N), .push(pushR), .pop(pop), .din(pwR),
		.head(headR), .full(rightFull), .empty(rightEmpty)
	);

	pwmTimer timer (
		.CLK(CLK), .RST_N(RST_N), .tick(tick), .ctrl(ctrl), .cycle(cycle),
		.irqMask(irqMask), .irqClear(irqClear), .restart(restart),
		.leftEmpty(leftEmpty), .rightEmpty(rightEmpty), .periodEnd(periodEnd),
		.pop(pop), .load(load), .hasData(hasData), .irqFlag(pwmIrq), .dmaReq(dmaReq)
	);

	pwmSampleScaler scaler (
		.CLK(CLK), .RST_N(RST_N), .tick(tick), .load(load), .hasData(hasData),
		.mono(ctrl.mono), .cycle(cycle), .headL(headL), .headR(headR),
		.sampleL(sampleL), .sampleR(sampleR)
	);

endmodule

`default_nettype wire

// ==== verilog/pwmSampleScaler.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmSampleScaler (
	input  wire                           CLK,
	input  wire                           RST_N,
	input  wire                           tick,
	input  wire                           load,
	input  wire [1:0]                     hasData,
	input  wire                           mono,
	input  wire pwmAudioPkg::cycle_t      cycle,
	input  wire pwmAudioPkg::pulseWidth_t headL,
	input  wire pwmAudioPkg::pulseWidth_t headR,
	output pwmAudioPkg::sample_t          sampleL,
	output pwmAudioPkg::sample_t          sampleR
);
	import pwmAudioPkg::*;

	pulseWidth_t dataL;
	pulseWidth_t dataR;
	logic [1:0]  outEn;

	// Offset from mid-cycle, left-justified into 16 bits
	function automatic sample_t toSample(input pulseWidth_t pw, input cycle_t cyc);
		logic [PW_W-1:0] half;
		logic [PW_W-1:0] ofsVal;
		half = {1'b0, cyc[PW_W-1:1]};
		if (pw == '0) ofsVal = '0;
		else if (pw > cyc) ofsVal = half;
		else ofsVal = pw - half;
		if (!cyc[PW_W-1]) return {ofsVal[PW_W-1], ofsVal[9:0], 5'b00000};
		else return {ofsVal, 4'b0000};
	endfunction

	always_ff @(posedge CLK) begin
		if (load) begin
			dataL <= mono ? headR : headL;
			dataR <= headR;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			outEn   <= 2'b00;
			sampleL <= '0;
			sampleR <= '0;
		end else begin
			if (tick) begin
				if (outEn[1]) sampleL <= toSample(dataL, cycle);
				if (outEn[0]) sampleR <= toSample(dataR, cycle);
			end
			if (load) outEn <= hasData;
			else if (tick) outEn <= 2'b00;	// Only the tick after load
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pwmTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmTimer (
	input  wire                      CLK,
	input  wire                      RST_N,
	input  wire                      tick,
	input  wire pwmRegPkg::pwmCtrl_t ctrl,
	input  wire pwmAudioPkg::cycle_t cycle,
	input  wire                      irqMask,
	input  wire                      irqClear,
	input  wire                      restart,
	input  wire                      leftEmpty,
	input  wire                      rightEmpty,
	output logic                     periodEnd,
	output logic                     pop,
	output logic                     load,
	output logic [1:0]               hasData,
	output logic                     irqFlag,
	output logic                     dmaReq
);
	import pwmAudioPkg::*;

	cycle_t    cycCnt;
	cycle_t    cycNext;
	interval_t intCnt;
	interval_t intNext;
	interval_t intLimit;
	logic      running;
	logic      intervalEnd;

	assign running   = (ctrl.lmd != 2'b00 || ctrl.rmd != 2'b00) && cycle != '0;
	assign cycNext   = cycCnt + 1'b1;
	assign periodEnd = tick & running & (cycNext == cycle);

	assign intNext     = intCnt + 1'b1;
	assign intLimit    = (ctrl.interval == '0) ? 4'd1 : ctrl.interval;	// 0 counts as 1
	assign intervalEnd = periodEnd & (intNext == intLimit);

	// Heads are sampled before this pop
	assign pop     = periodEnd;
	assign load    = periodEnd;
	assign hasData = ctrl.mono ? {2{~rightEmpty}} : {~leftEmpty, ~rightEmpty};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cycCnt <= '0;
			intCnt <= '0;
		end else if (restart) begin
			cycCnt <= '0;
			intCnt <= '0;
		end else if (tick) begin
			if (!running) begin
				cycCnt <= '0;
				intCnt <= '0;
			end else if (periodEnd) begin
				cycCnt <= '0;
				intCnt <= intervalEnd ? '0 : intNext;
			end else begin
				cycCnt <= cycNext;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			irqFlag <= 1'b0;
			dmaReq  <= 1'b0;
		end else begin
			if (intervalEnd && irqMask) irqFlag <= 1'b1;	// Sticky until cleared
			else if (irqClear) irqFlag <= 1'b0;
			if (tick) dmaReq <= intervalEnd & ctrl.rtp & ~dmaReq;	// One tick wide
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pulseQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module pulseQueue (
	input  wire                       CLK,
	input  wire                       RST_N,
	input  wire                       push,
	input  wire                       pop,
	input  wire pwmAudioPkg::pulseWidth_t din,
	output pwmAudioPkg::pulseWidth_t  head,
	output logic                      full,
	output logic                      empty
);
	import pwmAudioPkg::*;

	pulseWidth_t mem [QUEUE_DEPTH];
	queueCount_t wrPtr;
	queueCount_t rdPtr;
	queueCount_t count;
	queueCount_t countNext;
	logic        doPush;
	logic        doPop;

	function automatic queueCount_t ptrInc(input queueCount_t ptr);
		return (ptr == queueCount_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 2'd1;
	endfunction

	assign doPush = push & ~full;	// Full queue drops the push
	assign doPop  = pop & ~empty;
	assign head   = mem[rdPtr];

	always_comb begin
		countNext = count;
		if (doPush && !doPop) countNext = count + 2'd1;
		else if (!doPush && doPop) countNext = count - 2'd1;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			full  <= 1'b0;
			empty <= 1'b1;
		end else begin
			if (doPush) wrPtr <= ptrInc(wrPtr);
			if (doPop) rdPtr <= ptrInc(rdPtr);
			count <= countNext;
			full  <= countNext == queueCount_t'(QUEUE_DEPTH);
			empty <= countNext == '0;
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush) mem[wrPtr] <= din;
	end

endmodule

`default_nettype wire

// ==== verilog/pwmRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwmRegFile (
	input  wire                       CLK,
	input  wire                       RST_N,
	input  wire                       tick,
	input  wire pwmRegPkg::regBus_t   bus,
	input  wire                       periodEnd,
	input  wire                       irqFlag,
	input  wire                       leftFull,
	input  wire                       leftEmpty,
	input  wire                       rightFull,
	input  wire                       rightEmpty,
	output logic [15:0]               rdata,
	output logic                      rdValid,
	output pwmRegPkg::pwmCtrl_t       ctrl,
	output pwmAudioPkg::cycle_t       cycle,
	output logic                      irqMask,
	output logic                      irqClear,
	output logic                      restart,
	output logic                      pushL,
	output logic                      pushR,
	output pwmAudioPkg::pulseWidth_t  pwL,
	output pwmAudioPkg::pulseWidth_t  pwR
);
	import pwmRegPkg::*;
	import pwmAudioPkg::*;

	regOffset_t  ofs;
	logic        wrEn;
	logic        pendL;
	logic        pendR;
	logic [15:0] ctrlNew;
	logic [15:0] cycleNew;
	logic [15:0] maskNew;
	logic [15:0] pwNewL;
	logic [15:0] pwNewR;

	function automatic logic [15:0] laneWrite(input logic [15:0] cur, input logic [15:0] data,
			input logic [1:0] be, input logic [15:0] mask);
		logic [15:0] res;
		res = cur;
		if (be[1]) res[15:8] = data[15:8] & mask[15:8];
		if (be[0]) res[7:0] = data[7:0] & mask[7:0];
		return res;
	endfunction

	assign ofs  = {bus.addr[5:1], 1'b0};
	assign wrEn = bus.sel & bus.write;

	assign ctrlNew  = laneWrite(ctrl, bus.wdata, bus.byteEn, CTRL_MASK);
	assign cycleNew = laneWrite({{(16-PW_W){1'b0}}, cycle}, bus.wdata, bus.byteEn, CYCLE_MASK);
	assign maskNew  = laneWrite({15'h0000, irqMask}, bus.wdata, bus.byteEn, INT_MASK_MASK);
	assign pwNewL   = laneWrite({{(16-PW_W){1'b0}}, pwL}, bus.wdata, bus.byteEn, PW_MASK);
	assign pwNewR   = laneWrite({{(16-PW_W){1'b0}}, pwR}, bus.wdata, bus.byteEn, PW_MASK);

	assign restart  = wrEn & (ofs == PWM_CTRL_OFS || ofs == CYCLE_OFS);
	assign irqClear = wrEn & (ofs == PWM_CLR_OFS);

	// Pending pushes wait for a tick that does not pop
	assign pushL = pendL & tick & ~periodEnd;
	assign pushR = pendR & tick & ~periodEnd;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ctrl    <= '0;
			cycle   <= '0;
			irqMask <= 1'b0;
			pwL     <= '0;
			pwR     <= '0;
			pendL   <= 1'b0;
			pendR   <= 1'b0;
		end else begin
			if (pushL) pendL <= 1'b0;
			if (pushR) pendR <= 1'b0;
			if (wrEn) begin
				case (ofs)
					INT_MASK_OFS: irqMask <= maskNew[0];
					PWM_CTRL_OFS: ctrl <= pwmCtrl_t'(ctrlNew);
					CYCLE_OFS:    cycle <= cycleNew[PW_W-1:0];
					LEFT_PW_OFS: begin
						pwL   <= pwNewL[PW_W-1:0];
						pendL <= 1'b1;
					end
					RIGHT_PW_OFS: begin
						pwR   <= pwNewR[PW_W-1:0];
						pendR <= 1'b1;
					end
					MONO_PW_OFS: begin	// Both channels
						pwL   <= pwNewL[PW_W-1:0];
						pwR   <= pwNewR[PW_W-1:0];
						pendL <= 1'b1;
						pendR <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rdata   <= '0;
			rdValid <= 1'b0;
		end else begin
			rdValid <= bus.sel & ~bus.write;
			if (bus.sel && !bus.write) begin
				case (ofs)
					INT_MASK_OFS: rdata <= {12'h000, irqFlag, 2'b00, irqMask};
					PWM_CTRL_OFS: rdata <= ctrl;
					CYCLE_OFS:    rdata <= {{(16-PW_W){1'b0}}, cycle};
					LEFT_PW_OFS:  rdata <= {leftFull, leftEmpty, 14'h0000};
					RIGHT_PW_OFS: rdata <= {rightFull, rightEmpty, 14'h0000};
					MONO_PW_OFS:  rdata <= {rightFull, rightEmpty, 14'h0000};
					default:      rdata <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pwmAudioPkg.sv ====
`default_nettype none

package pwmAudioPkg;

	localparam int PW_W        = 12;
	localparam int QUEUE_DEPTH = 3;

	typedef logic [PW_W-1:0] pulseWidth_t;
	typedef logic [PW_W-1:0] cycle_t;	// Period length in ticks
	typedef logic [3:0]      interval_t;
	typedef logic signed [15:0] sample_t;
	typedef logic [1:0]      queueCount_t;

endpackage

`default_nettype wire

// ==== verilog/pwmRegPkg.sv ====
`default_nettype none

package pwmRegPkg;

	typedef logic [5:0] regOffset_t;	// Byte offset, bit 0 ignored

	localparam regOffset_t INT_MASK_OFS = 6'h00;
	localparam regOffset_t PWM_CLR_OFS  = 6'h1C;
	localparam regOffset_t PWM_CTRL_OFS = 6'h30;
	localparam regOffset_t CYCLE_OFS    = 6'h32;
	localparam regOffset_t LEFT_PW_OFS  = 6'h34;
	localparam regOffset_t RIGHT_PW_OFS = 6'h36;
	localparam regOffset_t MONO_PW_OFS  = 6'h38;

	// Writable bits per register
	localparam logic [15:0] CTRL_MASK     = 16'h0F9F;
	localparam logic [15:0] CYCLE_MASK    = 16'h0FFF;
	localparam logic [15:0] PW_MASK       = 16'h0FFF;
	localparam logic [15:0] INT_MASK_MASK = 16'h0001;

	typedef struct packed {
		logic       sel;
		logic       write;
		regOffset_t addr;
		logic [1:0] byteEn;	// Upper, lower
		logic [15:0] wdata;
	} regBus_t;

	typedef struct packed {
		logic [3:0] rsvHi;
		logic [3:0] interval;
		logic       rtp;	// DMA request enable
		logic [1:0] rsvMid;
		logic       mono;
		logic [1:0] rmd;
		logic [1:0] lmd;
	} pwmCtrl_t;

endpackage

`default_nettype wire
